/* sim.f */
kl_pkg.sv
ml_pkg.sv
ml_link_ctrl.sv
ml_frame_rx.sv
ml_frame_tx.sv
kl_req_align.sv
kl_tx_arb.sv
ml2kl_bridge.sv
ml2kl_bridge_tb.sv

/* Makefile */
# Verilator simulation of the MLink to KLink bridge
TOP = ml2kl_bridge_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench into sim.log and check it"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary -j 0 --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "ERRORS FOUND" sim.log; then echo "Simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* ml2kl_bridge_tb.sv */
`timescale 1ns/1ps

// Directed testbench for the MLink to KLink bridge
// A behavioral peer plays the far end of the link and the KLink side is driven by hand
module ml2kl_bridge_tb;

    import kl_pkg::*;
    import ml_pkg::*;

    // Six tests with room for 500 cycles each
    localparam int TIMEOUT_CYCLES = 3000;

    typedef struct packed {
        logic [KL_ADDR_W-1:0] addr;
        logic                 wen;
        logic [KL_DATA_W-1:0] wdata;
        logic [KL_MASK_W-1:0] wmask;
        logic [KL_SIZE_W-1:0] size;
        logic [KL_ID_W-1:0]   srcid;
    } kl_req_t;

    logic                 clk;
    logic                 rst;
    logic [KL_ADDR_W-1:0] kl_req_addr;
    logic                 kl_req_wen;
    logic [KL_DATA_W-1:0] kl_req_wdata;
    logic [KL_MASK_W-1:0] kl_req_wmask;
    logic [KL_SIZE_W-1:0] kl_req_size;
    logic [KL_ID_W-1:0]   kl_req_srcid;
    logic                 kl_req_valid;
    logic                 kl_req_ready;
    logic [KL_DATA_W-1:0] kl_resp_rdata;
    logic                 kl_resp_ren;
    logic [KL_SIZE_W-1:0] kl_resp_size;
    logic [KL_ID_W-1:0]   kl_resp_dstid;
    logic                 kl_resp_valid;
    logic                 kl_resp_ready;
    logic                 ml_abr;
    logic                 ml_bbr;
    logic [ML_WORD_W-1:0] ml_data_o;
    logic [ML_WORD_W-1:0] ml_data_i;
    logic                 ml_data_oe;
    logic                 ml_data_ie;
    logic [KL_ADDR_W-1:0] sideband;

    // Words the peer sends next, and the last frame it collected from the bridge
    logic [ML_WORD_W-1:0] send_words [4];
    int                   send_len;
    logic [ML_WORD_W-1:0] got_words [4];
    int                   got_len;

    // Accepted KLink requests, written by the responder and read in order by the tests
    kl_req_t     req_q [$];
    int          req_rd = 0;
    kl_req_t     beat;
    int          errors = 0;
    int          link_faults = 0;
    int          cycles = 0;
    logic [31:0] lcg_state = 32'd18847;
    logic        oe_q = 1'b0;
    logic        turn_ok_q = 1'b0;
    link_state_e link_state;

    ml2kl_bridge u_dut (.*);

    assign link_state = u_dut.u_link_ctrl.state;

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run stopped after %0d cycles, link controller in %s",
                     cycles, link_state.name());
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // KLink target side that takes every request beat the bridge completes
    always @(posedge clk) begin
        if (!rst && kl_req_valid && kl_req_ready) begin
            beat.addr  = kl_req_addr;
            beat.wen   = kl_req_wen;
            beat.wdata = kl_req_wdata;
            beat.wmask = kl_req_wmask;
            beat.size  = kl_req_size;
            beat.srcid = kl_req_srcid;
            req_q.push_back(beat);
        end
    end

    // Link watcher, sampled mid cycle where every level is settled
    always @(negedge clk) begin
        if (!rst) begin
            if (ml_data_oe && ml_abr) begin
                link_faults++;
                $display("%0t: bridge drives the data lines while the peer holds the bus (%s)",
                         $time, link_state.name());
            end
            // Driving must follow a full cycle of own request high and peer request low
            if (ml_data_oe && !oe_q && !turn_ok_q) begin
                link_faults++;
                $display("%0t: bridge started driving without a turnaround cycle", $time);
            end
            oe_q = ml_data_oe;
            turn_ok_q = ml_bbr && !ml_abr;
        end
    end

    // Halves are swapped so the poor low bits of the generator end up high
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {lcg_state[15:0], lcg_state[31:16]};
    endfunction

    function automatic logic [ML_WORD_W-1:0] make_header(input ml_op_e op,
            input logic [KL_SIZE_W-1:0] size, input logic [KL_ID_W-1:0] id, input logic den);
        logic [ML_WORD_W-1:0] w;
        w = '0;
        w[ML_OP_LSB +: ML_OP_W] = op;
        w[ML_SIZE_LSB +: KL_SIZE_W] = size;
        w[ML_ID_LSB +: KL_ID_W] = id;
        w[ML_DEN_BIT] = den;
        return w;
    endfunction

    // Lanes touched by a naturally aligned narrow access, otherwise every lane
    function automatic logic [KL_MASK_W-1:0] expected_mask(input logic [KL_SIZE_W-1:0] size,
            input logic [2:0] offs);
        int                  sz;
        int                  o;
        int                  bytes;
        logic [KL_MASK_W-1:0] m;
        sz = int'(size);
        o = int'(offs);
        bytes = 1 << sz;
        m = 8'hff;
        if (sz < 3 && (o % bytes) == 0) begin
            m = 8'((1 << bytes) - 1);
            m = m << o;
        end
        return m;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic check_ml_word(input string what, input logic [ML_WORD_W-1:0] got,
            input logic [ML_WORD_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_op(input string what, input ml_op_e got, input ml_op_e exp);
        if (got !== exp) begin
            errors++;
            $display("Fail %0t: %s is %s, expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    // Compares the oldest unchecked KLink request, write data only when asked to
    task automatic check_kl_req(input kl_req_t exp, input logic with_data);
        kl_req_t got;
        if (req_rd >= req_q.size()) begin
            errors++;
            $display("%0t: a KLink request was expected but none was accepted", $time);
        end else begin
            got = req_q[req_rd];
            req_rd++;
            if (got.addr !== exp.addr || got.wmask !== exp.wmask || got.size !== exp.size ||
                    got.wen !== exp.wen || got.srcid !== exp.srcid ||
                    (with_data && got.wdata !== exp.wdata)) begin
                errors++;
                $display("Fail %0t: KLink request addr %h mask %h size %0d wen %b id %0d data %h",
                         $time, got.addr, got.wmask, got.size, got.wen, got.srcid, got.wdata);
                $display("    expected addr %h mask %h size %0d wen %b id %0d data %h",
                         exp.addr, exp.wmask, exp.size, exp.wen, exp.srcid, exp.wdata);
            end
        end
    endtask

    task automatic wait_for_reqs(input int count);
        while (req_q.size() - req_rd < count) begin
            step();
        end
    endtask

    // Random id and data, and the request the bridge should make from the frame
    // Every write here is at most a doubleword, so KLink always sees size 3
    task automatic make_write_frame(input logic [KL_SIZE_W-1:0] size,
            input logic [KL_ADDR_W-1:0] addr, output kl_req_t exp);
        logic [31:0] r;
        logic [31:0] lo;
        logic [31:0] hi;
        r = lcg_next();
        lo = lcg_next();
        hi = lcg_next();
        send_words[0] = make_header(OP_WRITE, size, r[12:8], 1'b1);
        send_words[1] = addr;
        send_words[2] = lo;
        send_words[3] = hi;
        send_len = ML_LONG_WORDS;
        exp.addr  = addr & ~32'h7;
        exp.wen   = 1'b1;
        exp.wdata = {hi, lo};
        exp.wmask = expected_mask(size, addr[2:0]);
        exp.size  = 3'd3;
        exp.srcid = r[12:8];
    endtask

    // Peer claims the bus, idles one cycle, then puts out one word per cycle
    // In contend mode it raises its line in the cycle the bridge raises its own
    task automatic peer_send_frame(input logic contend);
        if (contend) begin
            while (!ml_bbr) begin
                step();
            end
        end else begin
            while (!ml_data_ie || ml_bbr) begin
                step();
            end
        end
        ml_abr = 1'b1;
        ml_data_i = '0;
        step();
        if (contend) begin
            check_bit("ml_bbr after losing arbitration", ml_bbr, 1'b0);
        end
        for (int i = 0; i < send_len; i++) begin
            ml_data_i = send_words[2'(i)];
            step();
        end
        ml_abr = 1'b0;
        ml_data_i = '0;
    endtask

    task automatic peer_collect_frame();
        got_len = 0;
        while (!ml_data_oe) begin
            step();
        end
        while (ml_data_oe) begin
            if (got_len < 4) begin
                got_words[2'(got_len)] = ml_data_o;
            end
            got_len++;
            step();
        end
        // Request line falls on the same edge as the data enable
        check_bit("ml_bbr after the last link word", ml_bbr, 1'b0);
    endtask

    task automatic check_frame(input ml_op_e op, input logic [KL_SIZE_W-1:0] size,
            input logic [KL_ID_W-1:0] id, input logic [ML_WORD_W-1:0] addr, input logic den,
            input logic [KL_DATA_W-1:0] data);
        int exp_len;
        exp_len = den ? ML_LONG_WORDS : ML_SHORT_WORDS;
        if (got_len != exp_len) begin
            errors++;
            $display("%0t: link frame has %0d words instead of %0d", $time, got_len, exp_len);
        end
        check_op("frame opcode", ml_op_e'(got_words[0][ML_OP_LSB +: ML_OP_W]), op);
        check_ml_word("frame header", got_words[0], make_header(op, size, id, den));
        check_ml_word("frame address word", got_words[1], addr);
        if (den && got_len == exp_len) begin
            check_ml_word("frame low data word", got_words[2], data[31:0]);
            check_ml_word("frame high data word", got_words[3], data[63:32]);
        end
    endtask

    // Holds the response on offer until the bridge takes it
    task automatic offer_response(input logic [KL_DATA_W-1:0] rdata, input logic ren,
            input logic [KL_SIZE_W-1:0] size, input logic [KL_ID_W-1:0] id);
        kl_resp_rdata = rdata;
        kl_resp_ren = ren;
        kl_resp_size = size;
        kl_resp_dstid = id;
        kl_resp_valid = 1'b1;
        while (!kl_resp_ready) begin
            step();
        end
        step();
        kl_resp_valid = 1'b0;
    endtask

    task automatic test_reset_state();
        check_bit("kl_req_valid after reset", kl_req_valid, 1'b0);
        check_bit("ml_bbr after reset", ml_bbr, 1'b0);
        check_bit("ml_data_oe after reset", ml_data_oe, 1'b0);
        check_bit("ml_data_ie after reset", ml_data_ie, 1'b1);
        check_bit("kl_resp_ready after reset", kl_resp_ready, 1'b1);
    endtask

    task automatic test_write_alignment();
        kl_req_t              exp;
        logic [31:0]          r;
        logic [KL_ADDR_W-1:0] addr;
        logic [KL_SIZE_W-1:0] size;
        for (int n = 0; n < 10; n++) begin
            r = lcg_next();
            size = {1'b0, r[29:28]};
            addr = lcg_next();
            // First two frames are misaligned on purpose
            if (n == 0) begin
                size = 3'd2;
                addr[2:0] = 3'd6;
            end
            if (n == 1) begin
                size = 3'd1;
                addr[2:0] = 3'd3;
            end
            make_write_frame(size, addr, exp);
            peer_send_frame(1'b0);
            check_bit("kl_req_valid one cycle after the last word", kl_req_valid, 1'b1);
            wait_for_reqs(1);
            check_kl_req(exp, 1'b1);
        end
    endtask

    task automatic test_read_response();
        kl_req_t              exp;
        logic [31:0]          r;
        logic [KL_ADDR_W-1:0] addr;
        logic [KL_DATA_W-1:0] rdata;
        r = lcg_next();
        addr = lcg_next();
        send_words[0] = make_header(OP_READ, {1'b0, r[29:28]}, r[12:8], 1'b0);
        send_words[1] = addr;
        send_len = ML_SHORT_WORDS;
        peer_send_frame(1'b0);
        check_bit("kl_req_valid one cycle after a read frame", kl_req_valid, 1'b1);
        wait_for_reqs(1);
        exp.addr  = addr & ~32'h7;
        exp.wen   = 1'b0;
        exp.wdata = '0;
        exp.wmask = expected_mask({1'b0, r[29:28]}, addr[2:0]);
        exp.size  = 3'd3;
        exp.srcid = r[12:8];
        check_kl_req(exp, 1'b0);
        rdata = {lcg_next(), 32'h0};
        rdata[31:0] = lcg_next();
        offer_response(rdata, 1'b1, 3'd3, r[12:8]);
        peer_collect_frame();
        check_frame(OP_RESP, 3'd3, r[12:8], '0, 1'b1, rdata);
        // Without read data the frame stops after the address word
        offer_response(rdata, 1'b0, 3'd3, r[12:8]);
        peer_collect_frame();
        check_frame(OP_RESP, 3'd3, r[12:8], '0, 1'b0, '0);
    endtask

    task automatic test_back_pressure();
        kl_req_t first;
        kl_req_t second;
        kl_req_ready = 1'b0;
        make_write_frame(3'd3, lcg_next(), first);
        peer_send_frame(1'b0);
        step();
        check_bit("ml_data_ie with the receive buffer full", ml_data_ie, 1'b0);
        make_write_frame(3'd0, lcg_next(), second);
        fork
            peer_send_frame(1'b0);
            begin
                repeat (10) begin
                    step();
                    check_bit("kl_req_valid under back-pressure", kl_req_valid, 1'b1);
                    check_bit("ml_data_ie under back-pressure", ml_data_ie, 1'b0);
                end
                kl_req_ready = 1'b1;
            end
        join
        wait_for_reqs(2);
        check_kl_req(first, 1'b1);
        check_kl_req(second, 1'b1);
    endtask

    task automatic test_sideband();
        logic [KL_ADDR_W-1:0] value;
        value = lcg_next();
        sideband = value;
        peer_collect_frame();
        check_frame(OP_NOTIFY, 3'd0, KL_NOTIFY_ID, value, 1'b0, '0);
        // A change that lands while a response waits is dropped
        sideband = lcg_next();
        offer_response('0, 1'b0, 3'd3, 5'd7);
        peer_collect_frame();
        check_frame(OP_RESP, 3'd3, 5'd7, '0, 1'b0, '0);
        repeat (40) begin
            step();
            check_bit("ml_data_oe with no frame due", ml_data_oe, 1'b0);
        end
    endtask

    task automatic test_contention();
        kl_req_t              exp;
        logic [KL_ADDR_W-1:0] value;
        make_write_frame(3'd2, lcg_next(), exp);
        value = lcg_next();
        sideband = value;
        peer_send_frame(1'b1);
        check_bit("kl_req_valid after the contended frame", kl_req_valid, 1'b1);
        peer_collect_frame();
        check_frame(OP_NOTIFY, 3'd0, KL_NOTIFY_ID, value, 1'b0, '0);
        wait_for_reqs(1);
        check_kl_req(exp, 1'b1);
    endtask

    initial begin
        rst = 1'b1;
        kl_req_ready = 1'b1;
        kl_resp_rdata = '0;
        kl_resp_ren = 1'b0;
        kl_resp_size = '0;
        kl_resp_dstid = '0;
        kl_resp_valid = 1'b0;
        ml_abr = 1'b0;
        ml_data_i = '0;
        sideband = '0;
        send_len = 0;
        got_len = 0;
        step();
        step();
        rst = 1'b0;
        step();
        test_reset_state();
        test_write_alignment();
        test_read_response();
        test_back_pressure();
        test_sideband();
        test_contention();
        $display("Run complete: %0d value errors, %0d link faults", errors, link_faults);
        if (errors + link_faults == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* ml2kl_bridge.sv */
`timescale 1ns/1ps

// MLink target side bridge onto the KLink system bus
module ml2kl_bridge (
    input  logic                         clk,
    input  logic                         rst,
    // KLink request channel
    output logic [kl_pkg::KL_ADDR_W-1:0] kl_req_addr,
    output logic                         kl_req_wen,
    output logic [kl_pkg::KL_DATA_W-1:0] kl_req_wdata,
    output logic [kl_pkg::KL_MASK_W-1:0] kl_req_wmask,
    output logic [kl_pkg::KL_SIZE_W-1:0] kl_req_size,
    output logic [kl_pkg::KL_ID_W-1:0]   kl_req_srcid,
    output logic                         kl_req_valid,
    input  logic                         kl_req_ready,
    // KLink response channel
    input  logic [kl_pkg::KL_DATA_W-1:0] kl_resp_rdata,
    input  logic                         kl_resp_ren,
    input  logic [kl_pkg::KL_SIZE_W-1:0] kl_resp_size,
    input  logic [kl_pkg::KL_ID_W-1:0]   kl_resp_dstid,
    input  logic                         kl_resp_valid,
    output logic                         kl_resp_ready,
    // MLink half duplex bus
    input  logic                         ml_abr,
    output logic                         ml_bbr,
    output logic [ml_pkg::ML_WORD_W-1:0] ml_data_o,
    input  logic [ml_pkg::ML_WORD_W-1:0] ml_data_i,
    output logic                         ml_data_oe,
    output logic                         ml_data_ie,
    input  logic [kl_pkg::KL_ADDR_W-1:0] sideband
);

    import kl_pkg::*;
    import ml_pkg::*;

    // Receive path from the link into the aligner
    logic                 rx_sample;
    logic                 rx_full;
    logic [KL_ADDR_W-1:0] req_addr;
    logic [KL_SIZE_W-1:0] req_size;

    // Transmit offer from the arbiter to the frame buffer
    ml_op_e               tx_op;
    logic [KL_ADDR_W-1:0] tx_addr;
    logic                 tx_den;
    logic [KL_DATA_W-1:0] tx_data;
    logic [KL_SIZE_W-1:0] tx_size;
    logic [KL_ID_W-1:0]   tx_id;
    logic                 tx_valid;
    logic                 tx_ready;
    logic                 tx_pending;
    logic                 tx_last;
    logic                 tx_advance;

    // Port names match the local nets one to one
    ml_link_ctrl u_link_ctrl (.*);
    ml_frame_rx  u_frame_rx  (.*);
    kl_req_align u_req_align (.*);
    kl_tx_arb    u_tx_arb    (.*);
    ml_frame_tx  u_frame_tx  (.*);

endmodule

/* kl_tx_arb.sv */
`timescale 1ns/1ps

// Chooses what the transmitter sends next
// A pending sideband notification goes before a KLink response
module kl_tx_arb (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [kl_pkg::KL_ADDR_W-1:0] sideband,
    input  logic [kl_pkg::KL_DATA_W-1:0] kl_resp_rdata,
    input  logic                         kl_resp_ren,
    input  logic [kl_pkg::KL_SIZE_W-1:0] kl_resp_size,
    input  logic [kl_pkg::KL_ID_W-1:0]   kl_resp_dstid,
    input  logic                         kl_resp_valid,
    input  logic                         tx_ready,
    output logic                         kl_resp_ready,
    output ml_pkg::ml_op_e               tx_op,
    output logic [kl_pkg::KL_ADDR_W-1:0] tx_addr,
    output logic                         tx_den,
    output logic [kl_pkg::KL_DATA_W-1:0] tx_data,
    output logic [kl_pkg::KL_SIZE_W-1:0] tx_size,
    output logic [kl_pkg::KL_ID_W-1:0]   tx_id,
    output logic                         tx_valid
);

    import kl_pkg::*;
    import ml_pkg::*;

    logic [KL_ADDR_W-1:0] sideband_q;
    logic                 notify_pending;

    // Previous sideband value for edge detection
    always_ff @(posedge clk) begin
        sideband_q <= sideband;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            notify_pending <= 1'b0;
        end else if (notify_pending && tx_ready) begin
            notify_pending <= 1'b0;
        end else if ((sideband != sideband_q) && !kl_resp_valid) begin
            // A change never cuts in front of a response already on offer
            notify_pending <= 1'b1;
        end
    end

    // The notification frame carries the live sideband value in its address word
    assign tx_valid = notify_pending || kl_resp_valid;
    assign tx_op    = notify_pending ? OP_NOTIFY : OP_RESP;
    assign tx_addr  = notify_pending ? sideband : '0;
    assign tx_den   = notify_pending ? 1'b0 : kl_resp_ren;
    assign tx_data  = notify_pending ? '0 : kl_resp_rdata;
    assign tx_size  = notify_pending ? '0 : kl_resp_size;
    assign tx_id    = notify_pending ? KL_NOTIFY_ID : kl_resp_dstid;

    // Responses stall while a notification owns the transmitter
    assign kl_resp_ready = !notify_pending && tx_ready;

endmodule

/* kl_req_align.sv */
`timescale 1ns/1ps

// Turns a sized access without a mask into an aligned doubleword access with byte mask
module kl_req_align (
    input  logic [kl_pkg::KL_ADDR_W-1:0] req_addr,
    input  logic [kl_pkg::KL_SIZE_W-1:0] req_size,
    output logic [kl_pkg::KL_ADDR_W-1:0] kl_req_addr,
    output logic [kl_pkg::KL_MASK_W-1:0] kl_req_wmask,
    output logic [kl_pkg::KL_SIZE_W-1:0] kl_req_size
);

    import kl_pkg::*;

    logic [KL_OFFS_W-1:0] offs;

    assign offs = req_addr[KL_OFFS_W-1:0];

    always_comb begin
        kl_req_addr = {req_addr[KL_ADDR_W-1:KL_OFFS_W], {KL_OFFS_W{1'b0}}};
        kl_req_size = (req_size < KL_DWORD_SIZE) ? KL_DWORD_SIZE : req_size;
        // Misaligned and full width accesses write every lane
        kl_req_wmask = KL_FULL_MASK;
        case (req_size)
            // A byte is always aligned
            3'd0: kl_req_wmask = 8'h01 << offs;
            3'd1: begin
                if (offs[0] == 1'b0) begin
                    kl_req_wmask = 8'h03 << offs;
                end
            end
            3'd2: begin
                if (offs[1:0] == 2'b00) begin
                    kl_req_wmask = 8'h0f << offs;
                end
            end
            default: ;
        endcase
    end

endmodule

/* ml_frame_tx.sv */
`timescale 1ns/1ps

// MLink frame transmitter
// Holds one outgoing frame and plays its words out as the controller advances
module ml_frame_tx (
    input  logic                         clk,
    input  logic                         rst,
    input  ml_pkg::ml_op_e               tx_op,
    input  logic [kl_pkg::KL_ADDR_W-1:0] tx_addr,
    input  logic                         tx_den,
    input  logic [kl_pkg::KL_DATA_W-1:0] tx_data,
    input  logic [kl_pkg::KL_SIZE_W-1:0] tx_size,
    input  logic [kl_pkg::KL_ID_W-1:0]   tx_id,
    input  logic                         tx_valid,
    input  logic                         tx_advance,
    output logic                         tx_ready,
    output logic                         tx_pending,
    output logic                         tx_last,
    output logic [ml_pkg::ML_WORD_W-1:0] ml_data_o
);

    import ml_pkg::*;
    import kl_pkg::*;

    logic                 pending;
    logic [1:0]           word_idx;
    logic [1:0]           last_idx;
    logic                 den_q;
    logic [ML_WORD_W-1:0] hdr_word;
    logic [ML_WORD_W-1:0] hdr_q;
    logic [ML_WORD_W-1:0] addr_q;
    logic [KL_DATA_W-1:0] data_q;

    // Header word packing
    always_comb begin
        hdr_word = '0;
        hdr_word[ML_OP_LSB +: ML_OP_W] = tx_op;
        hdr_word[ML_SIZE_LSB +: KL_SIZE_W] = tx_size;
        hdr_word[ML_ID_LSB +: KL_ID_W] = tx_id;
        hdr_word[ML_DEN_BIT] = tx_den;
    end

    // A new frame is taken only into an empty buffer
    assign tx_ready = !pending;
    assign tx_pending = pending;

    assign last_idx = den_q ? 2'(ML_LONG_WORDS - 1) : 2'(ML_SHORT_WORDS - 1);
    assign tx_last = pending && (word_idx == last_idx);

    always_ff @(posedge clk) begin
        if (rst) begin
            pending  <= 1'b0;
            word_idx <= 2'd0;
        end else if (tx_valid && tx_ready) begin
            pending  <= 1'b1;
            word_idx <= 2'd0;
        end else if (tx_advance) begin
            if (tx_last) begin
                pending  <= 1'b0;
                word_idx <= 2'd0;
            end else begin
                word_idx <= word_idx + 2'd1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (tx_valid && tx_ready) begin
            hdr_q  <= hdr_word;
            addr_q <= tx_addr;
            data_q <= tx_data;
            den_q  <= tx_den;
        end
    end

    // Word order is header, address, low data, high data
    always_comb begin
        case (word_idx)
            2'd0: ml_data_o = hdr_q;
            2'd1: ml_data_o = addr_q;
            2'd2: ml_data_o = data_q[ML_WORD_W-1:0];
            default: ml_data_o = data_q[KL_DATA_W-1:ML_WORD_W];
        endcase
    end

endmodule

/* ml_frame_rx.sv */
`timescale 1ns/1ps

// MLink frame receiver
// Assembles one peer request from link words and holds it until KLink takes it
module ml_frame_rx (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [ml_pkg::ML_WORD_W-1:0] ml_data_i,
    input  logic                         rx_sample,
    input  logic                         kl_req_ready,
    output logic                         rx_full,
    output logic [kl_pkg::KL_ADDR_W-1:0] req_addr,
    output logic [kl_pkg::KL_SIZE_W-1:0] req_size,
    output logic                         kl_req_wen,
    output logic [kl_pkg::KL_DATA_W-1:0] kl_req_wdata,
    output logic [kl_pkg::KL_ID_W-1:0]   kl_req_srcid,
    output logic                         kl_req_valid
);

    import ml_pkg::*;
    import kl_pkg::*;

    logic               in_frame;
    logic [1:0]         word_idx;
    logic [1:0]         last_idx;
    logic               den_q;
    logic [ML_OP_W-1:0] hdr_op;

    assign hdr_op = ml_data_i[ML_OP_LSB +: ML_OP_W];

    // Frame length depends on the data enable bit of the header
    assign last_idx = den_q ? 2'(ML_LONG_WORDS - 1) : 2'(ML_SHORT_WORDS - 1);

    // One entry buffer so a finished request alone makes it full
    assign rx_full = kl_req_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame     <= 1'b0;
            word_idx     <= 2'd0;
            kl_req_valid <= 1'b0;
        end else begin
            if (kl_req_valid && kl_req_ready) begin
                kl_req_valid <= 1'b0;
            end
            if (rx_sample) begin
                if (!in_frame) begin
                    // Any opcode other than idle opens a frame
                    if (hdr_op != OP_IDLE) begin
                        in_frame <= 1'b1;
                        word_idx <= 2'd1;
                    end
                end else if (word_idx == last_idx) begin
                    // Request goes out on the edge right after its last word
                    in_frame     <= 1'b0;
                    word_idx     <= 2'd0;
                    kl_req_valid <= 1'b1;
                end else begin
                    word_idx <= word_idx + 2'd1;
                end
            end
        end
    end

    // Field capture
    // Sampling stops while the buffer is full so the request stays stable
    always_ff @(posedge clk) begin
        if (rx_sample) begin
            if (!in_frame) begin
                req_size     <= ml_data_i[ML_SIZE_LSB +: KL_SIZE_W];
                kl_req_srcid <= ml_data_i[ML_ID_LSB +: KL_ID_W];
                den_q        <= ml_data_i[ML_DEN_BIT];
                kl_req_wen   <= (hdr_op == OP_WRITE);
            end else begin
                case (word_idx)
                    2'd1: req_addr <= ml_data_i;
                    2'd2: kl_req_wdata[ML_WORD_W-1:0] <= ml_data_i;
                    2'd3: kl_req_wdata[KL_DATA_W-1:ML_WORD_W] <= ml_data_i;
                    default: ;
                endcase
            end
        end
    end

endmodule

/* ml_link_ctrl.sv */
`timescale 1ns/1ps

// MLink bus ownership controller
// Decides when the bridge listens, when it competes for the bus and when it drives words
module ml_link_ctrl (
    input  logic clk,
    input  logic rst,
    // Peer bus request level
    input  logic ml_abr,
    // Transmitter holds a frame that still has to go out
    input  logic tx_pending,
    // Transmitter is putting its final word on the bus this cycle
    input  logic tx_last,
    // Receive buffer holds a request that KLink has not taken yet
    input  logic rx_full,
    output logic ml_bbr,
    output logic ml_data_oe,
    output logic ml_data_ie,
    output logic rx_sample,
    output logic tx_advance
);

    import ml_pkg::*;

    link_state_e state;
    link_state_e state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= LISTEN;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            LISTEN: begin
                // The bus request may only go up while the peer line is seen low
                if (tx_pending && !ml_abr) begin
                    state_nxt = ARBITRATE;
                end
            end
            ARBITRATE: begin
                // Both lines high in the same cycle means the peer wins
                // Back off and wait in LISTEN until the peer line drops again
                if (ml_abr) begin
                    state_nxt = LISTEN;
                end else begin
                    state_nxt = TURN;
                end
            end
            TURN: begin
                // Extra idle cycle so the peer has stopped driving the data lines
                // A peer that breaks the rules still never sees us drive on top of it
                if (ml_abr) begin
                    state_nxt = LISTEN;
                end else begin
                    state_nxt = SEND;
                end
            end
            SEND: begin
                if (tx_last) begin
                    state_nxt = RELEASE;
                end
            end
            RELEASE: begin
                state_nxt = LISTEN;
            end
            default: begin
                state_nxt = LISTEN;
            end
        endcase
    end

    // Own request line stays up from arbitration to the last word
    assign ml_bbr = (state == ARBITRATE) || (state == TURN) || (state == SEND);

    // Data lines are driven only while words are actually going out
    // Enable and request drop together on the edge after the last word
    assign ml_data_oe = (state == SEND);

    // Receive enable doubles as flow control toward the peer
    assign ml_data_ie = (state == LISTEN) && !rx_full;

    // Incoming words are taken whenever receive is enabled and we do not own the bus
    assign rx_sample = ml_data_ie && !ml_bbr;

    // One word per cycle with no gaps while sending
    assign tx_advance = (state == SEND);

endmodule

/* ml_pkg.sv */
// MLink chip-to-chip link definitions
package ml_pkg;

    // One link word per cycle on the shared bus
    localparam int ML_WORD_W = 32;

    // Header word layout
    localparam int ML_OP_W = 3;
    localparam int ML_OP_LSB = 0;
    localparam int ML_SIZE_LSB = 3;
    localparam int ML_ID_LSB = 6;
    localparam int ML_DEN_BIT = 11;

    // Header plus address, and optionally two data words with the low half first
    localparam int ML_SHORT_WORDS = 2;
    localparam int ML_LONG_WORDS = 4;

    // Link opcodes
    // Zero on the bus means no frame starts in that cycle
    typedef enum logic [ML_OP_W-1:0] {
        OP_IDLE   = 3'd0,
        OP_READ   = 3'd1,
        OP_WRITE  = 3'd2,
        OP_RESP   = 3'd3,
        OP_NOTIFY = 3'd4
    } ml_op_e;

    // Bus ownership states of the link controller
    typedef enum logic [2:0] {
        LISTEN,
        ARBITRATE,
        TURN,
        SEND,
        RELEASE
    } link_state_e;

endpackage

/* kl_pkg.sv */
// KLink system bus definitions shared by the bridge blocks
package kl_pkg;

    // Request and response field widths
    localparam int KL_ADDR_W = 32;
    localparam int KL_DATA_W = 64;
    localparam int KL_MASK_W = 8;
    // Size is log2 of the byte count
    localparam int KL_SIZE_W = 3;
    localparam int KL_ID_W = 5;

    // Source id that tags a sideband notification toward the peer
    localparam logic [KL_ID_W-1:0] KL_NOTIFY_ID = 5'd31;

    // Number of address bits that select a byte inside one doubleword
    localparam int KL_OFFS_W = 3;

    // KLink only sees full doubleword beats, so narrower sizes get raised to this
    localparam logic [KL_SIZE_W-1:0] KL_DWORD_SIZE = 3'd3;

    // Mask that enables every byte lane of a doubleword
    localparam logic [KL_MASK_W-1:0] KL_FULL_MASK = 8'hff;

endpackage
